/* hdl/axil_pkg.sv */
package axil_pkg;

   // default bus widths, overridden through the top level parameters
   localparam int axil_data_width = 32;
   localparam int axil_addr_width = 16;

   // only okay and decode error are ever produced
   typedef enum logic [1:0] {
      resp_okay   = 2'd0,
      resp_decerr = 2'd3
   } axil_resp_t;

   // one bank covers 4 KiB of byte address
   localparam int bank_addr_width = 12;

   // address map
   // upper bits above bank_addr_width equal to 0 select bank0
   // upper bits equal to 1 select bank1
   // every other address is answered with resp_decerr
   localparam logic [axil_addr_width-1:0] bank0_base = 16'h0000;
   localparam logic [axil_addr_width-1:0] bank1_base = 16'h1000;

endpackage

/* hdl/axil_if.sv */
`timescale 1ns/1ps

interface axil_if #(
   parameter int DATA_WIDTH = axil_pkg::axil_data_width,
   parameter int ADDR_WIDTH = axil_pkg::axil_addr_width
);
   import axil_pkg::*;

   // write address
   logic [ADDR_WIDTH-1:0]   awaddr;
   logic [2:0]              awprot;
   logic                    awvalid;
   logic                    awready;
   // write data
   logic [DATA_WIDTH-1:0]   wdata;
   logic [DATA_WIDTH/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   // write response
   axil_resp_t              bresp;
   logic                    bvalid;
   logic                    bready;
   // read address
   logic [ADDR_WIDTH-1:0]   araddr;
   logic [2:0]              arprot;
   logic                    arvalid;
   logic                    arready;
   // read data
   logic [DATA_WIDTH-1:0]   rdata;
   axil_resp_t              rresp;
   logic                    rvalid;
   logic                    rready;

   modport master (
      output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      output araddr, arprot, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport slave (
      input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      input  araddr, arprot, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

/* hdl/axil_host_bridge.sv */
`timescale 1ns/1ps

module axil_host_bridge #(
   parameter int DATA_WIDTH = axil_pkg::axil_data_width,
   parameter int ADDR_WIDTH = axil_pkg::axil_addr_width
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    req_valid,
   input  logic                    req_write,
   input  logic [ADDR_WIDTH-1:0]   req_addr,
   input  logic [DATA_WIDTH-1:0]   req_wdata,
   input  logic [DATA_WIDTH/8-1:0] req_wstrb,
   output logic                    rsp_valid,
   output logic [DATA_WIDTH-1:0]   rsp_rdata,
   output axil_pkg::axil_resp_t    rsp_resp,
   output logic                    busy,
   axil_if.master                  m
);
   import axil_pkg::*;

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_addr = 2'd1;
   localparam logic [1:0] st_resp = 2'd2;

   logic [1:0] state;
   logic       aw_left;
   logic       w_left;
   logic       ar_left;
   logic       resp_hs;

   // responses are never stalled
   assign m.bready = 1'b1;
   assign m.rready = 1'b1;
   assign m.awprot = 3'b000;
   assign m.arprot = 3'b000;

   // valids still waiting for their handshake after this edge
   assign aw_left = m.awvalid && !m.awready;
   assign w_left  = m.wvalid && !m.wready;
   assign ar_left = m.arvalid && !m.arready;
   assign resp_hs = (m.bvalid && m.bready) || (m.rvalid && m.rready);

   // busy covers the response cycle too
   assign busy = (state != st_idle) || rsp_valid;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= st_idle;
         m.awvalid <= 1'b0;
         m.wvalid  <= 1'b0;
         m.arvalid <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (req_valid) begin
                  state     <= st_addr;
                  m.awvalid <= req_write;
                  m.wvalid  <= req_write;
                  m.arvalid <= !req_write;
               end
            end
            st_addr: begin
               // each valid drops at its own handshake
               if (m.awready) begin
                  m.awvalid <= 1'b0;
               end
               if (m.wready) begin
                  m.wvalid <= 1'b0;
               end
               if (m.arready) begin
                  m.arvalid <= 1'b0;
               end
               if (!aw_left && !w_left && !ar_left) begin
                  state <= st_resp;
               end
            end
            default: begin
            end
         endcase
         // a bank can answer in the same cycle as the address handshake
         if (state != st_idle && resp_hs) begin
            state     <= st_idle;
            rsp_valid <= 1'b1;
         end
      end
   end

   // request fields held stable while the valids are up
   always_ff @(posedge clk) begin
      if (state == st_idle && req_valid) begin
         m.awaddr <= req_addr;
         m.araddr <= req_addr;
         m.wdata  <= req_wdata;
         m.wstrb  <= req_wstrb;
      end
      if (state != st_idle && resp_hs) begin
         rsp_rdata <= m.rvalid ? m.rdata : '0;
         rsp_resp  <= m.rvalid ? m.rresp : m.bresp;
      end
   end

   // host has no back-pressure, so one request at a time
   a_no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
      busy |-> !req_valid);

endmodule

/* hdl/axil_addr_decode.sv */
`timescale 1ns/1ps

module axil_addr_decode #(
   parameter int ADDR_WIDTH      = axil_pkg::axil_addr_width,
   parameter int BANK_ADDR_WIDTH = axil_pkg::bank_addr_width
) (
   input  logic   clk,
   input  logic   rst,
   axil_if.slave  s,
   axil_if.master m0,
   axil_if.master m1
);
   import axil_pkg::*;

   localparam logic [1:0] route_bk0 = 2'd0;
   localparam logic [1:0] route_bk1 = 2'd1;
   localparam logic [1:0] route_err = 2'd2;

   logic [1:0] aw_route;
   logic [1:0] ar_route;
   logic [1:0] b_route;
   logic [1:0] r_route;
   logic [1:0] w_route_q;
   logic [1:0] r_route_q;
   logic       err_wr_acc;
   logic       err_rd_acc;
   logic       err_bvalid;
   logic       err_rvalid;

   // compare the page above the bank offset with the map
   function automatic logic [1:0] decode(input logic [ADDR_WIDTH-1:0] addr);
      logic [ADDR_WIDTH-1:0] page;
      page = addr >> BANK_ADDR_WIDTH;
      if (page == (ADDR_WIDTH'(bank0_base) >> BANK_ADDR_WIDTH)) begin
         return route_bk0;
      end
      if (page == (ADDR_WIDTH'(bank1_base) >> BANK_ADDR_WIDTH)) begin
         return route_bk1;
      end
      return route_err;
   endfunction

   assign aw_route = decode(s.awaddr);
   assign ar_route = decode(s.araddr);

   // banks answer together with ready, before the route is registered
   assign b_route = s.awvalid ? aw_route : w_route_q;
   assign r_route = s.arvalid ? ar_route : r_route_q;

   // bank0 request side
   assign m0.awaddr  = s.awaddr;
   assign m0.awprot  = s.awprot;
   assign m0.awvalid = s.awvalid && (aw_route == route_bk0);
   assign m0.wdata   = s.wdata;
   assign m0.wstrb   = s.wstrb;
   assign m0.wvalid  = s.wvalid && (aw_route == route_bk0);
   assign m0.bready  = s.bready && (b_route == route_bk0);
   assign m0.araddr  = s.araddr;
   assign m0.arprot  = s.arprot;
   assign m0.arvalid = s.arvalid && (ar_route == route_bk0);
   assign m0.rready  = s.rready && (r_route == route_bk0);

   // bank1 request side
   assign m1.awaddr  = s.awaddr;
   assign m1.awprot  = s.awprot;
   assign m1.awvalid = s.awvalid && (aw_route == route_bk1);
   assign m1.wdata   = s.wdata;
   assign m1.wstrb   = s.wstrb;
   assign m1.wvalid  = s.wvalid && (aw_route == route_bk1);
   assign m1.bready  = s.bready && (b_route == route_bk1);
   assign m1.araddr  = s.araddr;
   assign m1.arprot  = s.arprot;
   assign m1.arvalid = s.arvalid && (ar_route == route_bk1);
   assign m1.rready  = s.rready && (r_route == route_bk1);

   // unmapped aw and w are taken together
   assign err_wr_acc = (aw_route == route_err) && s.awvalid && s.wvalid && !err_bvalid;
   assign err_rd_acc = (ar_route == route_err) && s.arvalid && !err_rvalid;

   always_comb begin
      case (aw_route)
         route_bk0: {s.awready, s.wready} = {m0.awready, m0.wready};
         route_bk1: {s.awready, s.wready} = {m1.awready, m1.wready};
         default:   {s.awready, s.wready} = {err_wr_acc, err_wr_acc};
      endcase
      case (b_route)
         route_bk0: {s.bvalid, s.bresp} = {m0.bvalid, m0.bresp};
         route_bk1: {s.bvalid, s.bresp} = {m1.bvalid, m1.bresp};
         default:   {s.bvalid, s.bresp} = {err_bvalid, resp_decerr};
      endcase
      case (ar_route)
         route_bk0: s.arready = m0.arready;
         route_bk1: s.arready = m1.arready;
         default:   s.arready = err_rd_acc;
      endcase
      case (r_route)
         route_bk0: {s.rvalid, s.rresp, s.rdata} = {m0.rvalid, m0.rresp, m0.rdata};
         route_bk1: {s.rvalid, s.rresp, s.rdata} = {m1.rvalid, m1.rresp, m1.rdata};
         default:   {s.rvalid, s.rresp, s.rdata} = {err_rvalid, resp_decerr, {$bits(s.rdata){1'b0}}};
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         w_route_q  <= route_bk0;
         r_route_q  <= route_bk0;
         err_bvalid <= 1'b0;
         err_rvalid <= 1'b0;
      end else begin
         if (s.awvalid && s.awready) begin
            w_route_q <= aw_route;
         end
         if (s.arvalid && s.arready) begin
            r_route_q <= ar_route;
         end
         // decode error answered one cycle after acceptance
         if (err_wr_acc) begin
            err_bvalid <= 1'b1;
         end else if (s.bready && b_route == route_err) begin
            err_bvalid <= 1'b0;
         end
         if (err_rd_acc) begin
            err_rvalid <= 1'b1;
         end else if (s.rready && r_route == route_err) begin
            err_rvalid <= 1'b0;
         end
      end
   end

   // a bank only answers on the route picked for it
   a_bk0_routed: assert property (@(posedge clk) disable iff (rst)
      !((m0.bvalid && b_route != route_bk0) || (m0.rvalid && r_route != route_bk0)));
   a_bk1_routed: assert property (@(posedge clk) disable iff (rst)
      !((m1.bvalid && b_route != route_bk1) || (m1.rvalid && r_route != route_bk1)));

endmodule

/* hdl/axil_ram.sv */
`timescale 1ns/1ps

module axil_ram #(
   parameter int  DATA_WIDTH      = axil_pkg::axil_data_width,
   parameter int  ADDR_WIDTH      = axil_pkg::axil_addr_width,
   parameter int  BANK_ADDR_WIDTH = axil_pkg::bank_addr_width,
   localparam int LANE_BITS       = $clog2(DATA_WIDTH / 8),
   localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - LANE_BITS
) (
   input  logic                       clk,
   input  logic                       rst,
   axil_if.slave                      s,
   input  logic [WORD_ADDR_WIDTH-1:0] dbg_addr,
   output logic [DATA_WIDTH-1:0]      dbg_data,
   input  logic                       dbg_wr_en,
   input  logic [WORD_ADDR_WIDTH-1:0] dbg_wr_addr,
   input  logic [DATA_WIDTH-1:0]      dbg_wr_data
);
   import axil_pkg::*;

   logic [DATA_WIDTH-1:0]      mem [2**WORD_ADDR_WIDTH];
   logic [ADDR_WIDTH-1:0]      aw_word;
   logic [ADDR_WIDTH-1:0]      ar_word;
   logic [WORD_ADDR_WIDTH-1:0] aw_idx;
   logic [WORD_ADDR_WIDTH-1:0] ar_idx;
   logic                       wr_acc;
   logic                       rd_acc;

   // byte address down to a word index inside the bank
   assign aw_word = s.awaddr >> LANE_BITS;
   assign ar_word = s.araddr >> LANE_BITS;
   assign aw_idx  = aw_word[WORD_ADDR_WIDTH-1:0];
   assign ar_idx  = ar_word[WORD_ADDR_WIDTH-1:0];

   // never fails a request
   assign s.bresp = resp_okay;
   assign s.rresp = resp_okay;

   // asynchronous backdoor read
   assign dbg_data = mem[dbg_addr];

   // skip the handshake cycle so a held request is not taken twice
   assign wr_acc = s.awvalid && s.wvalid && !s.awready && !s.wready
                   && (!s.bvalid || s.bready);
   assign rd_acc = s.arvalid && !s.arready && (!s.rvalid || s.rready);

   always_ff @(posedge clk) begin
      if (rst) begin
         s.awready <= 1'b0;
         s.wready  <= 1'b0;
         s.bvalid  <= 1'b0;
         s.arready <= 1'b0;
         s.rvalid  <= 1'b0;
      end else begin
         // ready pulses for one cycle and the response rises with it
         s.awready <= wr_acc;
         s.wready  <= wr_acc;
         s.arready <= rd_acc;
         if (wr_acc) begin
            s.bvalid <= 1'b1;
         end else if (s.bready) begin
            s.bvalid <= 1'b0;
         end
         if (rd_acc) begin
            s.rvalid <= 1'b1;
         end else if (s.rready) begin
            s.rvalid <= 1'b0;
         end
      end
   end

   // storage and read data
   always_ff @(posedge clk) begin
      if (dbg_wr_en) begin
         mem[dbg_wr_addr] <= dbg_wr_data;
      end
      if (wr_acc) begin
         // only strobed byte lanes change
         for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            if (s.wstrb[i]) begin
               mem[aw_idx][8*i +: 8] <= s.wdata[8*i +: 8];
            end
         end
      end
      if (rd_acc) begin
         s.rdata <= mem[ar_idx];
      end
   end

   // master holds a write address until it is taken
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      s.awvalid && !s.awready |=> s.awvalid);
   // backdoor and bus never write the same word in one cycle
   a_no_dbg_collision: assert property (@(posedge clk) disable iff (rst)
      !(wr_acc && dbg_wr_en && dbg_wr_addr == aw_idx));

endmodule

/* hdl/axil_mem_sys.sv */
`timescale 1ns/1ps

module axil_mem_sys #(
   parameter int  DATA_WIDTH      = axil_pkg::axil_data_width,
   parameter int  ADDR_WIDTH      = axil_pkg::axil_addr_width,
   parameter int  BANK_ADDR_WIDTH = axil_pkg::bank_addr_width,
   localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - $clog2(DATA_WIDTH / 8)
) (
   input  logic                       clk,
   input  logic                       rst,
   // host request and response
   input  logic                       req_valid,
   input  logic                       req_write,
   input  logic [ADDR_WIDTH-1:0]      req_addr,
   input  logic [DATA_WIDTH-1:0]      req_wdata,
   input  logic [DATA_WIDTH/8-1:0]    req_wstrb,
   output logic                       rsp_valid,
   output logic [DATA_WIDTH-1:0]      rsp_rdata,
   output logic [1:0]                 rsp_resp,
   output logic                       busy,
   // backdoor of bank0
   input  logic [WORD_ADDR_WIDTH-1:0] bk0_dbg_addr,
   output logic [DATA_WIDTH-1:0]      bk0_dbg_data,
   input  logic                       bk0_dbg_wr_en,
   input  logic [WORD_ADDR_WIDTH-1:0] bk0_dbg_wr_addr,
   input  logic [DATA_WIDTH-1:0]      bk0_dbg_wr_data,
   // backdoor of bank1
   input  logic [WORD_ADDR_WIDTH-1:0] bk1_dbg_addr,
   output logic [DATA_WIDTH-1:0]      bk1_dbg_data,
   input  logic                       bk1_dbg_wr_en,
   input  logic [WORD_ADDR_WIDTH-1:0] bk1_dbg_wr_addr,
   input  logic [DATA_WIDTH-1:0]      bk1_dbg_wr_data
);

   axil_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) host_bus ();
   axil_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) bank0_bus ();
   axil_if #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) bank1_bus ();

   axil_host_bridge #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_bridge (
      .clk, .rst, .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
      .rsp_valid, .rsp_rdata, .rsp_resp, .busy,
      .m (host_bus.master)
   );

   axil_addr_decode #(.ADDR_WIDTH(ADDR_WIDTH), .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)) u_decode (
      .clk, .rst,
      .s  (host_bus.slave),
      .m0 (bank0_bus.master),
      .m1 (bank1_bus.master)
   );

   axil_ram #(
      .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
   ) u_ram0 (
      .clk, .rst,
      .s           (bank0_bus.slave),
      .dbg_addr    (bk0_dbg_addr),
      .dbg_data    (bk0_dbg_data),
      .dbg_wr_en   (bk0_dbg_wr_en),
      .dbg_wr_addr (bk0_dbg_wr_addr),
      .dbg_wr_data (bk0_dbg_wr_data)
   );

   axil_ram #(
      .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
   ) u_ram1 (
      .clk, .rst,
      .s           (bank1_bus.slave),
      .dbg_addr    (bk1_dbg_addr),
      .dbg_data    (bk1_dbg_data),
      .dbg_wr_en   (bk1_dbg_wr_en),
      .dbg_wr_addr (bk1_dbg_wr_addr),
      .dbg_wr_data (bk1_dbg_wr_data)
   );

endmodule

/* sim/tb_axil_mem_sys.sv */
`timescale 1ns/1ps

module tb_axil_mem_sys;
   import axil_pkg::*;

   localparam int dw             = axil_data_width;
   localparam int aw             = axil_addr_width;
   localparam int sw             = dw / 8;
   localparam int lane_bits      = $clog2(sw);
   localparam int word_aw        = bank_addr_width - lane_bits;
   localparam int words          = 2 ** word_aw;
   localparam int timeout_cycles = 50;

   typedef struct {
      logic [dw-1:0] data;
      axil_resp_t    resp;
      string         what;
   } expect_t;

   logic               clk;
   logic               rst;
   logic               req_valid;
   logic               req_write;
   logic [aw-1:0]      req_addr;
   logic [dw-1:0]      req_wdata;
   logic [sw-1:0]      req_wstrb;
   logic               rsp_valid;
   logic [dw-1:0]      rsp_rdata;
   logic [1:0]         rsp_resp;
   logic               busy;
   logic [word_aw-1:0] bk0_dbg_addr;
   logic [dw-1:0]      bk0_dbg_data;
   logic               bk0_dbg_wr_en;
   logic [word_aw-1:0] bk0_dbg_wr_addr;
   logic [dw-1:0]      bk0_dbg_wr_data;
   logic [word_aw-1:0] bk1_dbg_addr;
   logic [dw-1:0]      bk1_dbg_data;
   logic               bk1_dbg_wr_en;
   logic [word_aw-1:0] bk1_dbg_wr_addr;
   logic [dw-1:0]      bk1_dbg_wr_data;

   // byte model of both banks keyed by full byte address
   logic [7:0] ref_mem [int];
   expect_t    expect_q [$];
   int         data_errors;
   int         resp_errors;
   int         flag_errors;
   int         other_errors;
   int         timeout_errors;

   axil_mem_sys #(
      .DATA_WIDTH(dw), .ADDR_WIDTH(aw), .BANK_ADDR_WIDTH(bank_addr_width)
   ) dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // preload word mixing every bit of the byte address
   function automatic logic [dw-1:0] fill_word(input logic [aw-1:0] addr);
      logic [31:0] a32;
      a32 = 32'(addr);
      return dw'((a32 * 32'h9e37_79b1) ^ 32'h5a3c_96e1);
   endfunction

   function automatic logic [dw-1:0] model_word(input logic [aw-1:0] addr);
      logic [dw-1:0] w;
      int            base;
      base = int'(addr >> lane_bits) << lane_bits;
      w = '0;
      for (int i = 0; i < sw; i++) begin
         if (ref_mem.exists(base + i)) begin
            w[8*i +: 8] = ref_mem[base + i];
         end
      end
      return w;
   endfunction

   function automatic void model_write(input logic [aw-1:0] addr, input logic [dw-1:0] data,
                                       input logic [sw-1:0] strb);
      int base;
      base = int'(addr >> lane_bits) << lane_bits;
      for (int i = 0; i < sw; i++) begin
         if (strb[i]) begin
            ref_mem[base + i] = data[8*i +: 8];
         end
      end
   endfunction

   // page 0 is bank0, page 1 is bank1, anything else is a decode error
   function automatic void expected_read(input logic [aw-1:0] addr, output logic [dw-1:0] data,
                                         output axil_resp_t resp);
      int page;
      page = int'(addr >> bank_addr_width);
      if (page == 0 || page == 1) begin
         data = model_word(addr);
         resp = resp_okay;
      end else begin
         data = '0;
         resp = resp_decerr;
      end
   endfunction

   function automatic logic [aw-1:0] random_bank_addr();
      logic [aw-1:0] word;
      word = aw'($urandom_range(0, words - 1)) << lane_bits;
      return (($urandom_range(0, 1) != 0) ? bank1_base : bank0_base) | word;
   endfunction

   task automatic check_data(input logic [dw-1:0] got, input logic [dw-1:0] exp,
                             input string what);
      if (got !== exp) begin
         data_errors++;
         $display("[ERROR] %0t ns: %s data 0x%h, expected 0x%h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
      if (got !== exp) begin
         resp_errors++;
         $display("[ERROR] %0t ns: %s resp %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         flag_errors++;
         $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("errors: data %0d, resp %0d, flag %0d, other %0d, timeout %0d",
               data_errors, resp_errors, flag_errors, other_errors, timeout_errors);
      if (data_errors + resp_errors + flag_errors + other_errors + timeout_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      @(negedge clk);
      while (busy) begin
         n++;
         if (n > timeout_cycles) begin
            timeout_errors++;
            $display("timeout: the DUT stayed busy for %0d cycles", timeout_cycles);
            finish_run();
         end
         @(negedge clk);
      end
   endtask

   // one request strobe with its expected response queued for the checker
   task automatic issue_req(input logic write, input logic [aw-1:0] addr,
                            input logic [dw-1:0] wdata, input logic [sw-1:0] wstrb);
      expect_t       e;
      logic [dw-1:0] exp_data;
      axil_resp_t    exp_resp;
      int            n;
      wait_idle();
      expected_read(addr, exp_data, exp_resp);
      if (write) begin
         exp_data = '0;
         if (exp_resp == resp_okay) begin
            model_write(addr, wdata, wstrb);
         end
      end
      e.data = exp_data;
      e.resp = exp_resp;
      e.what = $sformatf("%s 0x%h", write ? "write" : "read", addr);
      expect_q.push_back(e);
      @(posedge clk);
      req_valid <= 1'b1;
      req_write <= write;
      req_addr  <= addr;
      req_wdata <= wdata;
      req_wstrb <= wstrb;
      @(posedge clk);
      req_valid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rsp_valid) begin
         // busy from the cycle after the strobe
         check_flag(busy, 1'b1, {e.what, " busy while waiting"});
         n++;
         if (n > timeout_cycles) begin
            timeout_errors++;
            $display("timeout: no response to %s within %0d cycles", e.what, timeout_cycles);
            finish_run();
         end
         @(negedge clk);
      end
      check_flag(busy, 1'b1, {e.what, " busy with rsp_valid"});
      // busy ends with the response cycle
      @(negedge clk);
      check_flag(busy, 1'b0, {e.what, " busy after rsp_valid"});
   endtask

   // both banks at one word offset against the model
   task automatic check_backdoor(input logic [word_aw-1:0] idx, input string what);
      logic [aw-1:0] off;
      off = aw'(idx) << lane_bits;
      @(posedge clk);
      bk0_dbg_addr <= idx;
      bk1_dbg_addr <= idx;
      @(negedge clk);
      check_data(bk0_dbg_data, model_word(bank0_base | off), {what, " bank0 backdoor"});
      check_data(bk1_dbg_data, model_word(bank1_base | off), {what, " bank1 backdoor"});
   endtask

   task automatic poke_word(input int bank, input logic [word_aw-1:0] idx,
                            input logic [dw-1:0] data);
      @(posedge clk);
      if (bank == 0) begin
         bk0_dbg_wr_en   <= 1'b1;
         bk0_dbg_wr_addr <= idx;
         bk0_dbg_wr_data <= data;
      end else begin
         bk1_dbg_wr_en   <= 1'b1;
         bk1_dbg_wr_addr <= idx;
         bk1_dbg_wr_data <= data;
      end
      @(posedge clk);
      bk0_dbg_wr_en <= 1'b0;
      bk1_dbg_wr_en <= 1'b0;
      model_write(((bank == 0) ? bank0_base : bank1_base) | (aw'(idx) << lane_bits), data, '1);
   endtask

   // every word of both banks at one word per bank per cycle
   task automatic preload_banks();
      logic [aw-1:0] a0;
      logic [aw-1:0] a1;
      for (int i = 0; i < words; i++) begin
         a0 = bank0_base | (aw'(i) << lane_bits);
         a1 = bank1_base | (aw'(i) << lane_bits);
         @(posedge clk);
         bk0_dbg_wr_en   <= 1'b1;
         bk0_dbg_wr_addr <= word_aw'(i);
         bk0_dbg_wr_data <= fill_word(a0);
         bk1_dbg_wr_en   <= 1'b1;
         bk1_dbg_wr_addr <= word_aw'(i);
         bk1_dbg_wr_data <= fill_word(a1);
         model_write(a0, fill_word(a0), '1);
         model_write(a1, fill_word(a1), '1);
      end
      @(posedge clk);
      bk0_dbg_wr_en <= 1'b0;
      bk1_dbg_wr_en <= 1'b0;
   endtask

   // responses compared at the falling edge
   always @(negedge clk) begin : compare_responses
      expect_t e;
      if (!rst && rsp_valid) begin
         if (expect_q.size() == 0) begin
            other_errors++;
            $display("a response arrived with no request outstanding at %0t ns", $time);
         end else begin
            e = expect_q.pop_front();
            check_data(rsp_rdata, e.data, e.what);
            check_resp(axil_resp_t'(rsp_resp), e.resp, e.what);
         end
      end
   end

   initial begin : stimulus
      logic [aw-1:0]      addr;
      logic [dw-1:0]      data;
      logic [sw-1:0]      strb;
      logic [word_aw-1:0] idx;
      logic               wr;
      void'($urandom(32'hf957));
      data_errors     = 0;
      resp_errors     = 0;
      flag_errors     = 0;
      other_errors    = 0;
      timeout_errors  = 0;
      rst             = 1'b1;
      req_valid       = 1'b0;
      req_write       = 1'b0;
      req_addr        = '0;
      req_wdata       = '0;
      req_wstrb       = '0;
      bk0_dbg_addr    = '0;
      bk0_dbg_wr_en   = 1'b0;
      bk0_dbg_wr_addr = '0;
      bk0_dbg_wr_data = '0;
      bk1_dbg_addr    = '0;
      bk1_dbg_wr_en   = 1'b0;
      bk1_dbg_wr_addr = '0;
      bk1_dbg_wr_data = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(rsp_valid, 1'b0, "rsp_valid after reset");

      // preloaded words come back on the first reads
      preload_banks();
      issue_req(1'b0, bank0_base | 16'h0014, '0, '0);
      issue_req(1'b0, bank1_base | 16'h0ffc, '0, '0);

      // strobed writes read back through backdoor and bus
      for (int i = 0; i < 16; i++) begin
         addr = random_bank_addr();
         data = $urandom();
         strb = sw'($urandom());
         idx  = word_aw'(addr >> lane_bits);
         issue_req(1'b1, addr, data, strb);
         check_backdoor(idx, "strobed write");
         issue_req(1'b0, addr, '0, '0);
      end

      // random traffic over both banks
      for (int i = 0; i < 200; i++) begin
         addr = random_bank_addr();
         wr   = 1'($urandom_range(0, 1));
         data = $urandom();
         strb = sw'($urandom());
         issue_req(wr, addr, data, strb);
      end

      // unmapped space leaves both banks as they were
      for (int i = 0; i < 16; i++) begin
         addr = aw'($urandom_range(2 << bank_addr_width, 2 ** aw - 1));
         addr = (addr >> lane_bits) << lane_bits;
         idx  = word_aw'(addr >> lane_bits);
         issue_req(1'(i % 2), addr, $urandom(), '1);
         check_backdoor(idx, "unmapped access");
      end

      // backdoor write seen by the bus with the other bank untouched
      for (int b = 0; b < 2; b++) begin
         idx  = word_aw'($urandom_range(0, words - 1));
         data = $urandom();
         poke_word(b, idx, data);
         issue_req(1'b0, bank0_base | (aw'(idx) << lane_bits), '0, '0);
         issue_req(1'b0, bank1_base | (aw'(idx) << lane_bits), '0, '0);
         check_backdoor(idx, "backdoor write");
      end

      wait_idle();
      repeat (2) @(negedge clk);
      if (expect_q.size() != 0) begin
         other_errors++;
         $display("%0d expected responses never arrived", expect_q.size());
      end
      finish_run();
   end

endmodule

/* all.f */
hdl/axil_pkg.sv
hdl/axil_if.sv
hdl/axil_host_bridge.sv
hdl/axil_addr_decode.sv
hdl/axil_ram.sv
hdl/axil_mem_sys.sv
sim/tb_axil_mem_sys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module tb_axil_mem_sys \
   -f all.f \
   --Mdir obj_dir \
   -o tb_axil_mem_sys

./obj_dir/tb_axil_mem_sys 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi
